// File: Makefile
VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= sim failed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test: FAIL, see $(LOG)"; \
	  exit 1; \
	fi; \
	echo "test: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+test
logic/aluPkg.sv
logic/aluControl.sv
logic/bitSlice.sv
logic/rippleAlu.sv
logic/aluUnit.sv
test/aluTb.sv

// File: logic/aluControl.sv
`timescale 1ns/10ps

module aluControl (
  input  aluPkg::aluOpE   op,
  output aluPkg::aluCtrlS ctrl
);
  import aluPkg::*;

  // lookup table, fields are {sliceSel, invertB, flagEnable}
  always_comb begin
    ctrl = '{selSum, 1'b0, 1'b0};
    case (op)
      opAdd: begin
        ctrl = '{selSum, 1'b0, 1'b1};
      end
      opSub: begin
        ctrl = '{selSum, 1'b1, 1'b1};  // a + ~b + 1
      end
      opXor: begin
        ctrl = '{selXor, 1'b0, 1'b0};
      end
      opSlt: begin
        // subtract, but result is rebuilt later from the sign
        ctrl = '{selSum, 1'b1, 1'b0};
      end
      opAnd: begin
        ctrl = '{selNand, 1'b1, 1'b0}; // nand, inverted
      end
      opNand: begin
        ctrl = '{selNand, 1'b0, 1'b0};
      end
      opNor: begin
        ctrl = '{selNor, 1'b0, 1'b0};
      end
      opOr: begin
        ctrl = '{selNor, 1'b1, 1'b0};  // nor, inverted
      end
      default: begin
        ctrl = '{selSum, 1'b0, 1'b0};
      end
    endcase
  end

  // rippleAlu relies on this to tell slt apart from add and sub
  flagOnlyArith: assert final (!ctrl.flagEnable || isArithOp(op))
    else $error("aluControl: flagEnable set for op %s", op.name());

endmodule

// File: logic/aluPkg.sv
package aluPkg;

  localparam int dataWidth = 32;
  localparam int msbIdx    = dataWidth - 1;  // sign bit position
  localparam int opWidth   = 3;              // eight operations
  localparam int selWidth  = 2;              // four slice outputs

  // one operand or one result
  typedef logic [dataWidth-1:0] wordT;

  // opcodes match the command table of the slice ALU
  typedef enum logic [opWidth-1:0] {
    opAdd  = 3'd0,
    opSub  = 3'd1,
    opXor  = 3'd2,
    opSlt  = 3'd3,
    opAnd  = 3'd4,
    opNand = 3'd5,
    opNor  = 3'd6,
    opOr   = 3'd7
  } aluOpE;

  // which path of a slice drives its output
  typedef enum logic [selWidth-1:0] {
    selSum  = 2'd0,
    selXor  = 2'd1,
    selNand = 2'd2,
    selNor  = 2'd3
  } sliceSelE;

  // shared by all slices
  typedef struct packed {
    sliceSelE sliceSel;
    logic     invertB;     // also the carry into slice 0
    logic     flagEnable;  // only add and sub report flags
  } aluCtrlS;

  typedef struct packed {
    logic carry;
    logic zero;
    logic overflow;
  } aluFlagsS;

  typedef struct packed {
    aluOpE op;
    wordT  a;
    wordT  b;
  } aluReqS;

  typedef struct packed {
    wordT     result;
    aluFlagsS flags;
  } aluRespS;

  // true for the two ops that produce flags
  function automatic logic isArithOp(aluOpE op);
    return (op == opAdd) || (op == opSub);
  endfunction

endpackage

// File: logic/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
  input  logic            clk,
  input  logic            rstN,
  input  logic            opValid,
  input  aluPkg::aluReqS  req,
  output logic            resValid,
  output aluPkg::aluRespS resp
);
  import aluPkg::*;

  aluReqS  reqQ;        // captured request
  logic    stageValid;  // reqQ holds a live op
  aluRespS aluResp;     // combinational result of reqQ

  // valid pipe, one bit per stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stageValid <= 1'b0;
      resValid   <= 1'b0;
    end else begin
      stageValid <= opValid;
      resValid   <= stageValid;
    end
  end

  // payload follows its valid bit
  always_ff @(posedge clk) begin
    if (opValid) begin
      reqQ <= req;
    end
    if (stageValid) begin
      resp <= aluResp;
    end
  end

  rippleAlu u_rippleAlu (
    .req  (reqQ),
    .resp (aluResp)
  );

  respKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    resValid |-> !$isunknown(resp)
  ) else $error("aluUnit: unknown bits in resp %h", resp);

endmodule

// File: logic/bitSlice.sv
`timescale 1ns/10ps

module bitSlice (
  input  aluPkg::aluCtrlS ctrl,
  input  logic            a,
  input  logic            b,
  input  logic            carryIn,
  output logic            sum,
  output logic            carryOut
);
  import aluPkg::*;

  logic bEff;     // b after optional inversion
  logic addOut;
  logic xorOut;
  logic nandOut;
  logic norOut;

  // full adder
  assign bEff     = b ^ ctrl.invertB;
  assign addOut   = a ^ bEff ^ carryIn;
  assign carryOut = (a & bEff) | (carryIn & (a ^ bEff));

  // logic paths
  assign xorOut  = a ^ b;                      // plain b, inversion ignored
  assign nandOut = ~(a & b) ^ ctrl.invertB;    // gives and when inverted
  assign norOut  = ~(a | b) ^ ctrl.invertB;    // gives or when inverted

  // output mux
  always_comb begin
    case (ctrl.sliceSel)
      selSum: begin
        sum = addOut;
      end
      selXor: begin
        sum = xorOut;
      end
      selNand: begin
        sum = nandOut;
      end
      selNor: begin
        sum = norOut;
      end
      default: begin
        sum = addOut;
      end
    endcase
  end

endmodule

// File: logic/rippleAlu.sv
`timescale 1ns/10ps

module rippleAlu (
  input  aluPkg::aluReqS  req,
  output aluPkg::aluRespS resp
);
  import aluPkg::*;

  aluCtrlS            ctrl;
  wordT               sliceOut;  // raw per-bit outputs
  logic [dataWidth:0] carry;     // carry[i] feeds slice i
  logic               carryOut;
  logic               overflow;
  logic               isZero;
  logic               isSlt;
  logic               sltBit;

  aluControl u_aluControl (
    .op   (req.op),
    .ctrl (ctrl)
  );

  // subtract adds one through the first carry
  assign carry[0] = ctrl.invertB;

  generate
    for (genvar i = 0; i < dataWidth; i++) begin : g_slice
      bitSlice u_bitSlice (
        .ctrl     (ctrl),
        .a        (req.a[i]),
        .b        (req.b[i]),
        .carryIn  (carry[i]),
        .sum      (sliceOut[i]),
        .carryOut (carry[i+1])
      );
    end
  endgenerate

  assign carryOut = carry[dataWidth];
  assign overflow = carry[dataWidth] ^ carry[msbIdx];  // into msb vs out of msb
  assign isZero   = ~|sliceOut;

  // slt is the only op that picks the sum with flags off
  assign isSlt = (ctrl.sliceSel == selSum) && !ctrl.flagEnable;

  // sign of a - b, corrected when the subtraction wrapped
  assign sltBit = overflow ? req.a[msbIdx] : sliceOut[msbIdx];

  always_comb begin
    if (isSlt) begin
      resp.result = wordT'(sltBit);  // upper bits cleared
    end else begin
      resp.result = sliceOut;
    end
    resp.flags.carry    = ctrl.flagEnable & carryOut;
    resp.flags.zero     = ctrl.flagEnable & isZero;
    resp.flags.overflow = ctrl.flagEnable & overflow;
  end

  // checks decode and flag masking together
  flagsOnlyArith: assert final (isArithOp(req.op) || resp.flags == '0)
    else $error("rippleAlu: flags %b for op %s", resp.flags, req.op.name());

endmodule

// File: test/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected response, built from the result rules
function automatic aluRespS expectedResp(input aluReqS r);
  aluRespS            e;
  logic [dataWidth:0] wide;     // extra bit holds the carry out
  wordT               bEff;     // b as seen by the adder
  logic               addOne;   // +1 of two's complement subtract
  logic               lessThan;
  e = '0;
  case (r.op)
    opAdd, opSub: begin
      addOne = (r.op == opSub);
      bEff = addOne ? ~r.b : r.b;
      wide = {1'b0, r.a} + {1'b0, bEff} + {{dataWidth{1'b0}}, addOne};
      e.result = wide[dataWidth-1:0];
      e.flags.carry = wide[dataWidth];
      e.flags.zero = (e.result == '0);
      // same input signs but a different result sign
      e.flags.overflow = (r.a[dataWidth-1] == bEff[dataWidth-1]) &&
                         (e.result[dataWidth-1] != r.a[dataWidth-1]);
    end
    opSlt: begin
      lessThan = ($signed(r.a) < $signed(r.b));
      e.result = {{(dataWidth-1){1'b0}}, lessThan};
    end
    opXor:  e.result = r.a ^ r.b;
    opAnd:  e.result = r.a & r.b;
    opNand: e.result = ~(r.a & r.b);
    opNor:  e.result = ~(r.a | r.b);
    opOr:   e.result = r.a | r.b;
    default: begin
      e = '0;
    end
  endcase
  return e;
endfunction

`endif

// File: test/aluTb.sv
`timescale 1ns/10ps

module aluTb;
  import aluPkg::*;

  `include "aluModel.svh"

  localparam int drainLimit = 50;  // cycles to wait for stragglers

  typedef struct packed {
    aluRespS     resp;
    logic [31:0] dueCycle;  // cycle count when the result must show
  } expEntryS;

  logic    clk;
  logic    rstN;
  logic    opValid;
  aluReqS  req;
  logic    resValid;
  aluRespS resp;

  expEntryS    expQ[$];
  logic [31:0] rngState;
  logic [31:0] cycle;
  string       testName;
  int          errorCount;
  int          resultCount;
  int          testCount;

  aluUnit u_aluUnit (
    .clk      (clk),
    .rstN     (rstN),
    .opValid  (opValid),
    .req      (req),
    .resValid (resValid),
    .resp     (resp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 32'd1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // a quarter of the operands are corner values
  function automatic wordT pickOperand();
    logic [31:0] r;
    r = nextRand();
    case (r[3:0])
      4'd0: return '0;
      4'd1: return '1;
      4'd2: return 32'h8000_0000;  // most negative
      4'd3: return 32'h7fff_ffff;  // most positive
      default: return nextRand();
    endcase
  endfunction

  // mode 0 arith, 1 logic, 2 slt, else any op
  function automatic aluOpE pickOp(input int mode);
    logic [31:0] r;
    r = nextRand();
    if (mode == 0) begin
      return r[0] ? opSub : opAdd;
    end else if (mode == 2) begin
      return opSlt;
    end else if (mode == 1) begin
      case (r % 5)
        0: return opXor;
        1: return opAnd;
        2: return opNand;
        3: return opNor;
        default: return opOr;
      endcase
    end
    return aluOpE'(r[2:0]);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("error %s expected %h actual %h", name, expVal, actVal);
      errorCount++;
    end
  endtask

  // results are taken where all outputs are settled
  always @(negedge clk) begin
    expEntryS pending;
    if (rstN) begin
      if (resValid) begin
        if (expQ.size() == 0) begin
          $display("test %s: a result arrived with no request pending", testName);
          errorCount++;
        end else begin
          pending = expQ.pop_front();
          resultCount++;
          checkValue({testName, " result"}, pending.resp.result, resp.result);
          checkValue({testName, " carry"}, 32'(pending.resp.flags.carry),
                     32'(resp.flags.carry));
          checkValue({testName, " zero"}, 32'(pending.resp.flags.zero),
                     32'(resp.flags.zero));
          checkValue({testName, " overflow"}, 32'(pending.resp.flags.overflow),
                     32'(resp.flags.overflow));
          checkValue({testName, " arrival cycle"}, pending.dueCycle, cycle);
        end
      end
      if (opValid) begin  // sampled on the next rising edge
        pending.resp = expectedResp(req);
        pending.dueCycle = cycle + 32'd2;
        expQ.push_back(pending);
      end
    end
  end

  task automatic drain();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < drainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("test %s: %0d results never arrived", testName, expQ.size());
      errorCount++;
      expQ.delete();
    end
    repeat (3) @(posedge clk);  // room for extra results to show up
  endtask

  task automatic runPhase(input string name, input int mode, input int count);
    int          sent;
    int          errStart;
    int          resStart;
    logic [31:0] r;
    aluReqS      nextReq;
    testName = name;
    errStart = errorCount;
    resStart = resultCount;
    sent = 0;
    while (sent < count) begin
      @(posedge clk);
      r = nextRand();
      if (r[1:0] != 2'b00) begin  // busy on about 3 of 4 cycles
        nextReq.op = pickOp(mode);
        nextReq.a = pickOperand();
        nextReq.b = (r[4:2] == 3'd0) ? nextReq.a : pickOperand();
        req <= nextReq;
        opValid <= 1'b1;
        sent++;
      end else begin
        opValid <= 1'b0;
      end
    end
    @(posedge clk);
    opValid <= 1'b0;
    drain();
    testCount++;
    $display("test %s done: %0d results, %0d errors", name,
             resultCount - resStart, errorCount - errStart);
  endtask

  task automatic checkIdle();
    int errStart;
    testName = "resetIdle";
    errStart = errorCount;
    repeat (6) begin
      @(negedge clk);
      checkValue("resetIdle resValid", 32'd0, 32'(resValid));
    end
    drain();
    testCount++;
    $display("test resetIdle done: %0d errors", errorCount - errStart);
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    opValid = 1'b0;
    req = '0;
    rngState = 32'h3a04;
    cycle = '0;
    errorCount = 0;
    resultCount = 0;
    testCount = 0;
    testName = "reset";
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    checkIdle();
    runPhase("arith", 0, 300);
    runPhase("logic", 1, 200);
    runPhase("slt", 2, 200);
    runPhase("stream", 3, 400);
    $display("tests %0d, results %0d, errors %0d", testCount, resultCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
